// File: hsv_core_defs.svh
`ifndef HSV_CORE_DEFS_SVH
`define HSV_CORE_DEFS_SVH

// Datapath and commit order tag widths
`define HSV_XLEN 32
`define HSV_TOKEN_BITS 3

// Restart addresses
`define HSV_RESET_PC 32'h0000_1000
`define HSV_TRAP_VECTOR 32'h0000_0100

// Multiplier result latency in cycles
`define HSV_MUL_CYCLES 4

`endif

// File: hsv_core_pkg.sv
`include "hsv_core_defs.svh"

package hsv_core_pkg;

  typedef logic [`HSV_XLEN-1:0] word;
  typedef logic [4:0] reg_addr;
  typedef logic [`HSV_TOKEN_BITS-1:0] insn_token;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_MUL,
    OP_BEQ,
    OP_BNE,
    OP_ECALL
  } opcode_t;

  typedef enum logic {
    EXC_NONE,
    EXC_ECALL
  } exception_t;

  typedef struct packed {
    logic trap;
    logic flush;
  } commit_action_t;

  typedef struct packed {
    insn_token token;
    reg_addr   rd_addr;
  } commit_common_t;

  // Everything a unit hands to commit
  typedef struct packed {
    commit_common_t common;
    commit_action_t action;
    logic           writeback;
    word            result;
    word            next_pc;
    exception_t     exception_cause;
    word            exception_value;
  } commit_data_t;

  typedef enum logic [2:0] {
    ISSUE_RUN,
    ISSUE_WAIT,
    FLUSH_REQ,
    FLUSH_DROP,
    FLUSH_WAIT
  } issue_state_t;

endpackage

// File: hsv_core_issue.sv
`include "hsv_core_defs.svh"

module hsv_core_issue
  import hsv_core_pkg::*;
(
  input  logic      clk_core,
  input  logic      rst_core_n,
  input  logic      insn_valid_i,
  input  opcode_t   insn_op_i,
  input  reg_addr   insn_rd_i,
  input  word       insn_a_i,
  input  word       insn_b_i,
  input  word       insn_imm_i,
  input  logic      alu_busy_i,
  input  logic      mul_busy_i,
  input  logic      br_busy_i,
  input  logic      ctrl_commit_i,
  input  logic      ctrl_flush_begin_i,
  input  logic      ctrl_trap_i,
  input  word       ctrl_next_pc_i,
  input  logic      flush_ack_i,
  output logic      insn_ready_o,
  output opcode_t   disp_op_o,
  output insn_token disp_token_o,
  output word       disp_pc_o,
  output reg_addr   disp_rd_o,
  output word       disp_a_o,
  output word       disp_b_o,
  output word       disp_imm_o,
  output logic      alu_valid_o,
  output logic      mul_valid_o,
  output logic      br_valid_o,
  output logic      flush_req_o,
  output word       flush_target_o
);

  issue_state_t state_q;
  logic         pend_q;
  logic [2:0]   inflight_q;
  insn_token    token_q;
  word          pc_q;
  word          target_q;
  logic         disp_fire;
  logic         accept;
  logic         serialize;

  // Route the held instruction to a free unit
  assign alu_valid_o = pend_q && !alu_busy_i && (disp_op_o inside {OP_ADD, OP_SUB, OP_XOR});
  assign mul_valid_o = pend_q && !mul_busy_i && (disp_op_o == OP_MUL);
  assign br_valid_o  = pend_q && !br_busy_i && (disp_op_o inside {OP_BEQ, OP_BNE, OP_ECALL});
  assign disp_fire   = alu_valid_o | mul_valid_o | br_valid_o;

  assign insn_ready_o   = (state_q == ISSUE_RUN) && (!pend_q || disp_fire);
  assign accept         = insn_valid_i && insn_ready_o;
  assign serialize      = insn_op_i inside {OP_BEQ, OP_BNE, OP_ECALL};
  assign flush_req_o    = (state_q == FLUSH_REQ);
  assign flush_target_o = target_q;

  // Reset enters the tail of a flush so the first ack clears everything
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      state_q    <= FLUSH_DROP;
      pend_q     <= 1'b0;
      inflight_q <= '0;
      token_q    <= '0;
      pc_q       <= `HSV_RESET_PC;
      target_q   <= `HSV_RESET_PC;
    end else begin
      if (accept) begin
        token_q <= token_q + 1'b1;
        pc_q    <= pc_q + word'(4);
        pend_q  <= 1'b1;
      end else if (disp_fire) begin
        pend_q <= 1'b0;
      end
      inflight_q <= inflight_q + 3'(disp_fire) - 3'(ctrl_commit_i);

      case (state_q)
        ISSUE_RUN: begin
          if (accept && serialize) begin
            state_q <= ISSUE_WAIT;
          end
        end
        ISSUE_WAIT: begin
          if (ctrl_flush_begin_i) begin
            state_q <= FLUSH_WAIT;
          end else if (ctrl_trap_i) begin
            target_q <= `HSV_TRAP_VECTOR;
            state_q  <= FLUSH_REQ;
          end else if (!pend_q && inflight_q == '0) begin
            state_q <= ISSUE_RUN;
          end
        end
        // Branch target lands in ctrl_next_pc one cycle after commit
        FLUSH_WAIT: begin
          target_q <= ctrl_next_pc_i;
          state_q  <= FLUSH_REQ;
        end
        FLUSH_REQ: begin
          if (flush_ack_i) begin
            state_q <= FLUSH_DROP;
          end
        end
        FLUSH_DROP: begin
          if (flush_ack_i) begin
            token_q    <= '0;
            inflight_q <= '0;
            pend_q     <= 1'b0;
            pc_q       <= target_q;
          end else begin
            state_q <= ISSUE_RUN;
          end
        end
        default: state_q <= ISSUE_RUN;
      endcase
    end
  end

  always_ff @(posedge clk_core) begin
    if (accept) begin
      disp_op_o    <= insn_op_i;
      disp_token_o <= token_q;
      disp_pc_o    <= pc_q;
      disp_rd_o    <= insn_rd_i;
      disp_a_o     <= insn_a_i;
      disp_b_o     <= insn_b_i;
      disp_imm_o   <= insn_imm_i;
    end
  end

  // Request may only drop once commit has acknowledged it
  a_flush_req_held: assert property (
    @(posedge clk_core) disable iff (!rst_core_n)
    $fell(flush_req_o) |-> flush_ack_i
  );

endmodule

// File: hsv_core_alu.sv
`include "hsv_core_defs.svh"

module hsv_core_alu
  import hsv_core_pkg::*;
(
  input  logic         clk_core,
  input  logic         rst_core_n,
  input  logic         valid_i,
  input  opcode_t      op_i,
  input  insn_token    token_i,
  input  word          pc_i,
  input  reg_addr      rd_i,
  input  word          a_i,
  input  word          b_i,
  input  logic         ready_i,
  output logic         busy_o,
  output logic         valid_o,
  output commit_data_t data_o
);

  logic full_q;
  word  result;

  always_comb begin
    case (op_i)
      OP_SUB:  result = a_i - b_i;
      OP_XOR:  result = a_i ^ b_i;
      default: result = a_i + b_i;
    endcase
  end

  // Slot stays full until commit takes it
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      full_q <= 1'b0;
    end else if (valid_i) begin
      full_q <= 1'b1;
    end else if (valid_o && ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_core) begin
    if (valid_i) begin
      data_o                 <= '0;
      data_o.common.token    <= token_i;
      data_o.common.rd_addr  <= rd_i;
      data_o.writeback       <= 1'b1;
      data_o.result          <= result;
      data_o.next_pc         <= pc_i + word'(4);
      data_o.exception_cause <= EXC_NONE;
    end
  end

  assign busy_o  = full_q;
  assign valid_o = full_q;

endmodule

// File: hsv_core_mul.sv
`include "hsv_core_defs.svh"

module hsv_core_mul
  import hsv_core_pkg::*;
(
  input  logic         clk_core,
  input  logic         rst_core_n,
  input  logic         valid_i,
  input  opcode_t      op_i,
  input  insn_token    token_i,
  input  word          pc_i,
  input  reg_addr      rd_i,
  input  word          a_i,
  input  word          b_i,
  input  logic         ready_i,
  output logic         busy_o,
  output logic         valid_o,
  output commit_data_t data_o
);

  localparam int CNT_W = $clog2(`HSV_MUL_CYCLES + 1);

  logic             full_q;
  logic [CNT_W-1:0] cnt_q;
  word              product;

  // Low word only
  assign product = a_i * b_i;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      full_q <= 1'b0;
      cnt_q  <= '0;
    end else if (valid_i) begin
      full_q <= 1'b1;
      cnt_q  <= CNT_W'(`HSV_MUL_CYCLES - 1);
    end else if (valid_o && ready_i) begin
      full_q <= 1'b0;
    end else if (full_q && cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_core) begin
    if (valid_i) begin
      data_o                 <= '0;
      data_o.common.token    <= token_i;
      data_o.common.rd_addr  <= rd_i;
      data_o.writeback       <= 1'b1;
      data_o.result          <= product;
      data_o.next_pc         <= pc_i + word'(4);
      data_o.exception_cause <= EXC_NONE;
    end
  end

  assign busy_o  = full_q;
  assign valid_o = full_q && (cnt_q == '0);

  // Issue must route only multiplies here, and never into a full slot
  a_mul_no_overrun: assert property (
    @(posedge clk_core) disable iff (!rst_core_n)
    valid_i |-> !busy_o && op_i == OP_MUL
  );

endmodule

// File: hsv_core_branch.sv
`include "hsv_core_defs.svh"

module hsv_core_branch
  import hsv_core_pkg::*;
(
  input  logic         clk_core,
  input  logic         rst_core_n,
  input  logic         valid_i,
  input  opcode_t      op_i,
  input  insn_token    token_i,
  input  word          pc_i,
  input  reg_addr      rd_i,
  input  word          a_i,
  input  word          b_i,
  input  word          imm_i,
  input  logic         ready_i,
  output logic         busy_o,
  output logic         valid_o,
  output commit_data_t data_o
);

  logic         full_q;
  logic         taken;
  commit_data_t resolved;

  assign taken = (op_i == OP_BEQ) ? (a_i == b_i) : (op_i == OP_BNE) && (a_i != b_i);

  // No writeback from this unit
  always_comb begin
    resolved                 = '0;
    resolved.common.token    = token_i;
    resolved.common.rd_addr  = rd_i;
    resolved.next_pc         = pc_i + word'(4);
    resolved.exception_cause = EXC_NONE;
    if (op_i == OP_ECALL) begin
      resolved.action.trap     = 1'b1;
      resolved.exception_cause = EXC_ECALL;
      resolved.exception_value = pc_i;
    end else if (taken) begin
      resolved.action.flush = 1'b1;
      resolved.next_pc      = pc_i + imm_i;
    end
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      full_q <= 1'b0;
    end else if (valid_i) begin
      full_q <= 1'b1;
    end else if (valid_o && ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_core) begin
    if (valid_i) begin
      data_o <= resolved;
    end
  end

  assign busy_o  = full_q;
  assign valid_o = full_q;

endmodule

// File: hsv_core_commit.sv
`include "hsv_core_defs.svh"

module hsv_core_commit
  import hsv_core_pkg::*;
(
  input  logic         clk_core,
  input  logic         rst_core_n,
  input  commit_data_t alu_data_i,
  input  commit_data_t mul_data_i,
  input  commit_data_t br_data_i,
  input  logic         alu_valid_i,
  input  logic         mul_valid_i,
  input  logic         br_valid_i,
  input  logic         flush_req_i,
  input  word          flush_target_i,
  output logic         alu_ready_o,
  output logic         mul_ready_o,
  output logic         br_ready_o,
  output logic         flush_ack_o,
  output logic         ctrl_flush_begin_o,
  output logic         ctrl_trap_o,
  output exception_t   ctrl_trap_cause_o,
  output word          ctrl_trap_value_o,
  output word          ctrl_next_pc_o,
  output logic         ctrl_commit_o,
  output logic         wr_en_o,
  output reg_addr      wr_addr_o,
  output word          wr_data_o
);

  insn_token      token_q;
  logic           alu_committable;
  logic           mul_committable;
  logic           br_committable;
  commit_data_t   used_data;
  commit_action_t action;
  logic           general_commit;
  logic           token_enable;
  logic           token_clear;

  // Only the unit holding the oldest token may retire
  assign alu_ready_o = (alu_data_i.common.token == token_q);
  assign mul_ready_o = (mul_data_i.common.token == token_q);
  assign br_ready_o  = (br_data_i.common.token == token_q);

  assign alu_committable = alu_valid_i && alu_ready_o;
  assign mul_committable = mul_valid_i && mul_ready_o;
  assign br_committable  = br_valid_i && br_ready_o;

  // At most one source is nonzero, so OR acts as a mux
  assign used_data = (alu_committable ? alu_data_i : '0)
                   | (mul_committable ? mul_data_i : '0)
                   | (br_committable ? br_data_i : '0);

  assign action         = used_data.action;
  assign general_commit = (alu_committable | mul_committable | br_committable) & !action.trap;

  assign ctrl_commit_o      = general_commit;
  assign ctrl_flush_begin_o = action.flush;

  assign wr_en_o   = used_data.writeback & !action.trap;
  assign wr_addr_o = used_data.common.rd_addr;
  assign wr_data_o = used_data.result;

  assign token_enable = general_commit & !action.flush;
  assign token_clear  = flush_ack_o & !flush_req_i;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      token_q        <= '0;
      ctrl_trap_o    <= 1'b0;
      ctrl_next_pc_o <= `HSV_RESET_PC;
      flush_ack_o    <= 1'b1;
    end else begin
      flush_ack_o <= flush_req_i;
      ctrl_trap_o <= action.trap;
      if (token_clear) begin
        token_q        <= '0;
        ctrl_next_pc_o <= flush_target_i;
      end else begin
        if (token_enable) begin
          token_q <= token_q + 1'b1;
        end
        if (general_commit) begin
          ctrl_next_pc_o <= used_data.next_pc;
        end
      end
    end
  end

  always_ff @(posedge clk_core) begin
    ctrl_trap_cause_o <= used_data.exception_cause;
    ctrl_trap_value_o <= used_data.exception_value;
  end

  // Tokens are unique among units in flight
  a_single_committer: assert property (
    @(posedge clk_core) disable iff (!rst_core_n)
    $onehot0({alu_committable, mul_committable, br_committable})
  );

endmodule

// File: hsv_core_backend.sv
`include "hsv_core_defs.svh"

module hsv_core_backend
  import hsv_core_pkg::*;
(
  input  logic       clk_core,
  input  logic       rst_core_n,
  input  logic       insn_valid_i,
  input  opcode_t    insn_op_i,
  input  reg_addr    insn_rd_i,
  input  word        insn_a_i,
  input  word        insn_b_i,
  input  word        insn_imm_i,
  output logic       insn_ready_o,
  output logic       wr_en_o,
  output reg_addr    wr_addr_o,
  output word        wr_data_o,
  output logic       commit_o,
  output word        next_pc_o,
  output logic       trap_o,
  output exception_t trap_cause_o,
  output word        trap_value_o
);

  opcode_t      disp_op;
  insn_token    disp_token;
  word          disp_pc;
  reg_addr      disp_rd;
  word          disp_a;
  word          disp_b;
  word          disp_imm;
  logic         alu_valid;
  logic         mul_valid;
  logic         br_valid;
  logic         alu_busy;
  logic         mul_busy;
  logic         br_busy;
  commit_data_t alu_data;
  commit_data_t mul_data;
  commit_data_t br_data;
  logic         alu_done;
  logic         mul_done;
  logic         br_done;
  logic         alu_ready;
  logic         mul_ready;
  logic         br_ready;
  logic         flush_req;
  logic         flush_ack;
  word          flush_target;
  logic         flush_begin;

  hsv_core_issue hsv_core_issue_i (
    .clk_core           (clk_core),
    .rst_core_n         (rst_core_n),
    .insn_valid_i       (insn_valid_i),
    .insn_op_i          (insn_op_i),
    .insn_rd_i          (insn_rd_i),
    .insn_a_i           (insn_a_i),
    .insn_b_i           (insn_b_i),
    .insn_imm_i         (insn_imm_i),
    .alu_busy_i         (alu_busy),
    .mul_busy_i         (mul_busy),
    .br_busy_i          (br_busy),
    .ctrl_commit_i      (commit_o),
    .ctrl_flush_begin_i (flush_begin),
    .ctrl_trap_i        (trap_o),
    .ctrl_next_pc_i     (next_pc_o),
    .flush_ack_i        (flush_ack),
    .insn_ready_o       (insn_ready_o),
    .disp_op_o          (disp_op),
    .disp_token_o       (disp_token),
    .disp_pc_o          (disp_pc),
    .disp_rd_o          (disp_rd),
    .disp_a_o           (disp_a),
    .disp_b_o           (disp_b),
    .disp_imm_o         (disp_imm),
    .alu_valid_o        (alu_valid),
    .mul_valid_o        (mul_valid),
    .br_valid_o         (br_valid),
    .flush_req_o        (flush_req),
    .flush_target_o     (flush_target)
  );

  hsv_core_alu hsv_core_alu_i (
    .clk_core   (clk_core),
    .rst_core_n (rst_core_n),
    .valid_i    (alu_valid),
    .op_i       (disp_op),
    .token_i    (disp_token),
    .pc_i       (disp_pc),
    .rd_i       (disp_rd),
    .a_i        (disp_a),
    .b_i        (disp_b),
    .ready_i    (alu_ready),
    .busy_o     (alu_busy),
    .valid_o    (alu_done),
    .data_o     (alu_data)
  );

  hsv_core_mul hsv_core_mul_i (
    .clk_core   (clk_core),
    .rst_core_n (rst_core_n),
    .valid_i    (mul_valid),
    .op_i       (disp_op),
    .token_i    (disp_token),
    .pc_i       (disp_pc),
    .rd_i       (disp_rd),
    .a_i        (disp_a),
    .b_i        (disp_b),
    .ready_i    (mul_ready),
    .busy_o     (mul_busy),
    .valid_o    (mul_done),
    .data_o     (mul_data)
  );

  hsv_core_branch hsv_core_branch_i (
    .clk_core   (clk_core),
    .rst_core_n (rst_core_n),
    .valid_i    (br_valid),
    .op_i       (disp_op),
    .token_i    (disp_token),
    .pc_i       (disp_pc),
    .rd_i       (disp_rd),
    .a_i        (disp_a),
    .b_i        (disp_b),
    .imm_i      (disp_imm),
    .ready_i    (br_ready),
    .busy_o     (br_busy),
    .valid_o    (br_done),
    .data_o     (br_data)
  );

  hsv_core_commit hsv_core_commit_i (
    .clk_core           (clk_core),
    .rst_core_n         (rst_core_n),
    .alu_data_i         (alu_data),
    .mul_data_i         (mul_data),
    .br_data_i          (br_data),
    .alu_valid_i        (alu_done),
    .mul_valid_i        (mul_done),
    .br_valid_i         (br_done),
    .flush_req_i        (flush_req),
    .flush_target_i     (flush_target),
    .alu_ready_o        (alu_ready),
    .mul_ready_o        (mul_ready),
    .br_ready_o         (br_ready),
    .flush_ack_o        (flush_ack),
    .ctrl_flush_begin_o (flush_begin),
    .ctrl_trap_o        (trap_o),
    .ctrl_trap_cause_o  (trap_cause_o),
    .ctrl_trap_value_o  (trap_value_o),
    .ctrl_next_pc_o     (next_pc_o),
    .ctrl_commit_o      (commit_o),
    .wr_en_o            (wr_en_o),
    .wr_addr_o          (wr_addr_o),
    .wr_data_o          (wr_data_o)
  );

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

endmodule

// File: tb_hsv_core_backend.sv
`include "hsv_core_defs.svh"

module tb_hsv_core_backend
  import hsv_core_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          RESET_CYCLES = 8;
  localparam int          ROW_CYCLES   = 40;
  localparam logic [31:0] SEED         = 32'h2be1_40f0;

  typedef struct {
    opcode_t op;
    reg_addr rd;
    word     a;
    word     b;
    word     imm;
  } row_t;

  typedef struct {
    int      row;
    bit      is_trap;
    bit      wb;
    reg_addr rd;
    word     data;
    word     next_pc;
    word     trap_pc;
  } commit_event_t;

  logic       clk_core;
  logic       rst_core_n;
  logic       insn_valid;
  opcode_t    insn_op;
  reg_addr    insn_rd;
  word        insn_a;
  word        insn_b;
  word        insn_imm;
  logic       insn_ready;
  logic       wr_en;
  reg_addr    wr_addr;
  word        wr_data;
  logic       commit;
  word        next_pc;
  logic       trap;
  exception_t trap_cause;
  word        trap_value;

  row_t          rows[$];
  commit_event_t expq[$];
  bit            next_pc_due;
  word           next_pc_exp;
  int            next_pc_row;
  bit            trap_vec_wait;

  tb_clock_gen #(.PERIOD_NS(8.0)) tb_clock_gen_i (.clk_o(clk_core));

  hsv_core_backend hsv_core_backend_i (
    .clk_core     (clk_core),
    .rst_core_n   (rst_core_n),
    .insn_valid_i (insn_valid),
    .insn_op_i    (insn_op),
    .insn_rd_i    (insn_rd),
    .insn_a_i     (insn_a),
    .insn_b_i     (insn_b),
    .insn_imm_i   (insn_imm),
    .insn_ready_o (insn_ready),
    .wr_en_o      (wr_en),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data),
    .commit_o     (commit),
    .next_pc_o    (next_pc),
    .trap_o       (trap),
    .trap_cause_o (trap_cause),
    .trap_value_o (trap_value)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input word exp, input word act);
    if (act !== exp) begin
      report_failure($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input reg_addr exp, input reg_addr act);
    if (act !== exp) begin
      report_failure($sformatf("FAIL %s: expected x%0d, actual x%0d", name, exp, act));
    end
  endtask

  task automatic check_cause(input string name, input exception_t exp, input exception_t act);
    if (act !== exp) begin
      report_failure($sformatf("FAIL %s: expected %s, actual %s", name, exp.name(),
                               act.name()));
    end
  endtask

  task automatic put_row(input opcode_t op, input reg_addr rd, input word a, input word b,
                         input word imm, input bit filler);
    row_t r;
    r.op  = op;
    r.rd  = rd;
    r.a   = filler ? word'($urandom()) : a;
    r.b   = filler ? word'($urandom()) : b;
    r.imm = imm;
    rows.push_back(r);
  endtask

  task automatic load_rows();
    put_row(OP_ADD, 5'd1, 32'd5, 32'd7, 32'd0, 1'b0);
    put_row(OP_SUB, 5'd2, 32'd3, 32'd10, 32'd0, 1'b0);
    put_row(OP_XOR, 5'd3, 32'hf0f0_1234, 32'h0ff0_4321, 32'd0, 1'b0);
    // Multiply ahead of younger ALU work
    put_row(OP_MUL, 5'd4, 32'd1234, 32'd5678, 32'd0, 1'b0);
    put_row(OP_ADD, 5'd5, 32'd0, 32'd0, 32'd0, 1'b1);
    put_row(OP_SUB, 5'd6, 32'd0, 32'd0, 32'd0, 1'b1);
    put_row(OP_BEQ, 5'd0, 32'd1, 32'd2, 32'h20, 1'b0);
    put_row(OP_BNE, 5'd0, 32'd3, 32'd3, 32'h10, 1'b0);
    put_row(OP_XOR, 5'd7, 32'd0, 32'd0, 32'd0, 1'b1);
    put_row(OP_BEQ, 5'd0, 32'd9, 32'd9, 32'h40, 1'b0);
    put_row(OP_ADD, 5'd8, 32'd0, 32'd0, 32'd0, 1'b1);
    put_row(OP_MUL, 5'd9, 32'hffff_fff0, 32'd3, 32'd0, 1'b0);
    put_row(OP_ADD, 5'd10, 32'd0, 32'd0, 32'd0, 1'b1);
    // Taken backwards
    put_row(OP_BNE, 5'd0, 32'd1, 32'd2, 32'hffff_fff8, 1'b0);
    put_row(OP_SUB, 5'd11, 32'd0, 32'd0, 32'd0, 1'b1);
    put_row(OP_ECALL, 5'd0, 32'd0, 32'd0, 32'd0, 1'b0);
    put_row(OP_ADD, 5'd12, 32'd0, 32'd0, 32'd0, 1'b1);
    put_row(OP_XOR, 5'd13, 32'd0, 32'd0, 32'd0, 1'b1);
    put_row(OP_MUL, 5'd14, 32'h0001_0003, 32'h0002_0005, 32'd0, 1'b0);
    put_row(OP_ADD, 5'd15, 32'd0, 32'd0, 32'd0, 1'b1);
  endtask

  function automatic word expected_value(input opcode_t op, input word a, input word b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_XOR:  return a ^ b;
      default: return a * b;
    endcase
  endfunction

  // Reference model walks the table in program order
  task automatic build_expected();
    word           pc;
    bit            taken;
    commit_event_t ev;
    pc = `HSV_RESET_PC;
    foreach (rows[i]) begin
      taken      = (rows[i].op == OP_BEQ && rows[i].a == rows[i].b) ||
                   (rows[i].op == OP_BNE && rows[i].a != rows[i].b);
      ev.row     = i;
      ev.is_trap = (rows[i].op == OP_ECALL);
      ev.wb      = rows[i].op inside {OP_ADD, OP_SUB, OP_XOR, OP_MUL};
      ev.rd      = rows[i].rd;
      ev.data    = expected_value(rows[i].op, rows[i].a, rows[i].b);
      ev.trap_pc = pc;
      if (ev.is_trap) begin
        ev.next_pc = `HSV_TRAP_VECTOR;
      end else if (taken) begin
        ev.next_pc = pc + rows[i].imm;
      end else begin
        ev.next_pc = pc + 32'd4;
      end
      expq.push_back(ev);
      pc = ev.next_pc;
    end
  endtask

  task automatic offer_row(input int idx);
    bit accepted;
    insn_valid = 1'b1;
    insn_op    = rows[idx].op;
    insn_rd    = rows[idx].rd;
    insn_a     = rows[idx].a;
    insn_b     = rows[idx].b;
    insn_imm   = rows[idx].imm;
    accepted   = 1'b0;
    while (!accepted) begin
      // Ready only moves on rising edges
      accepted = insn_ready;
      @(negedge clk_core);
    end
    insn_valid = 1'b0;
  endtask

  task automatic watch_outputs();
    commit_event_t ev;
    forever begin
      @(negedge clk_core);
      if (next_pc_due) begin
        check_word($sformatf("row %0d next_pc", next_pc_row), next_pc_exp, next_pc);
        next_pc_due = 1'b0;
      end
      if (trap_vec_wait && next_pc == `HSV_TRAP_VECTOR) begin
        trap_vec_wait = 1'b0;
      end
      if (wr_en && !commit) begin
        report_failure("Register write seen without a commit");
      end
      // Trap report belongs to an older instruction than any commit here
      if (trap) begin
        if (expq.size() == 0) begin
          report_failure("Trap reported with no instruction left to retire");
        end
        ev = expq.pop_front();
        if (!ev.is_trap) begin
          report_failure($sformatf("Row %0d trapped but should have committed", ev.row));
        end
        check_cause($sformatf("row %0d trap_cause", ev.row), EXC_ECALL, trap_cause);
        check_word($sformatf("row %0d trap_value", ev.row), ev.trap_pc, trap_value);
        trap_vec_wait = 1'b1;
      end
      if (commit) begin
        if (trap_vec_wait) begin
          report_failure("Commit seen before next_pc moved to the trap vector");
        end
        if (expq.size() == 0) begin
          report_failure("Commit seen with no instruction left to retire");
        end
        ev = expq.pop_front();
        if (ev.is_trap) begin
          report_failure($sformatf("Row %0d committed but should have trapped", ev.row));
        end
        check_word($sformatf("row %0d wr_en", ev.row), word'(ev.wb), word'(wr_en));
        if (ev.wb) begin
          check_addr($sformatf("row %0d wr_addr", ev.row), ev.rd, wr_addr);
          check_word($sformatf("row %0d wr_data", ev.row), ev.data, wr_data);
        end
        next_pc_due = 1'b1;
        next_pc_exp = ev.next_pc;
        next_pc_row = ev.row;
      end
    end
  endtask

  task automatic run_watchdog(input int cycles);
    repeat (cycles) @(posedge clk_core);
    report_failure($sformatf("Timeout: the run did not finish within %0d cycles", cycles));
  endtask

  initial begin
    int gap;
    void'($urandom(SEED));
    insn_valid    = 1'b0;
    insn_op       = OP_ADD;
    insn_rd       = '0;
    insn_a        = '0;
    insn_b        = '0;
    insn_imm      = '0;
    rst_core_n    = 1'b0;
    next_pc_due   = 1'b0;
    next_pc_exp   = '0;
    next_pc_row   = 0;
    trap_vec_wait = 1'b0;
    load_rows();
    build_expected();
    fork
      run_watchdog(rows.size() * ROW_CYCLES + RESET_CYCLES);
    join_none
    repeat (RESET_CYCLES) @(negedge clk_core);
    rst_core_n = 1'b1;
    fork
      watch_outputs();
    join_none
    foreach (rows[i]) begin
      gap = $urandom_range(3);
      // Back to back after a multiply so the younger ALU row overtakes it
      if (i > 0 && rows[i-1].op == OP_MUL) begin
        gap = 0;
      end
      repeat (gap) @(negedge clk_core);
      offer_row(i);
    end
    while (expq.size() != 0 || next_pc_due || trap_vec_wait) begin
      @(negedge clk_core);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

// File: hsv_core_backend.f
+incdir+.
hsv_core_pkg.sv
hsv_core_issue.sv
hsv_core_alu.sv
hsv_core_mul.sv
hsv_core_branch.sv
hsv_core_commit.sv
hsv_core_backend.sv
tb_clock_gen.sv
tb_hsv_core_backend.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_hsv_core_backend
FILELIST  ?= hsv_core_backend.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, look for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
